// ==== rtl/regs_cfg.svh ====
`ifndef REGS_CFG_SVH
`define REGS_CFG_SVH

// accumulator banks, sixteen bytes each
`define REG_BANKS       4

// bank nibbles relative to rfp
`define REG_CURBANK     4'he
`define REG_PREVBANK    4'hd
// source nibble that always reads as zero
`define REG_ZERO_NIB    4'h4

// debug dump map
`define DMP_PTR_BASE    8'h40
`define DMP_SR_HI       8'h50
`define DMP_SR_LO       8'h51

// stack pointer occupies the top pointer bytes
`define XSP_BASE        12

// indexed addressing step field
`define STEP_1          2'd0
`define STEP_2          2'd1
`define STEP_4          2'd2

`endif

// ==== rtl/regs_pkg.sv ====
package regs_pkg;

    // code as issued by the decoder
    typedef struct packed {
        logic [3:0] bank_nib;
        logic [3:0] byte_idx;
    } code_raw_t;

    // code after bank-relative nibbles are replaced
    typedef struct packed {
        logic       is_ptr;
        logic       spare;
        logic [5:0] acc_addr;
    } code_abs_t;

    typedef union packed {
        code_raw_t raw;
        code_abs_t resolved;
    } reg_code_u;

    // register write command from the core
    typedef struct packed {
        logic       data_sel;
        logic [2:0] alu_we;
        logic [2:0] ram_we;
        logic       flag_only;
    } reg_wr_t;

    // indexed addressing command
    typedef struct packed {
        logic      idx_en;
        reg_code_u idx_sel;
        logic [1:0] step;
        logic      inc;
        logic      dec;
    } idx_cmd_t;

    // register file pointer command
    typedef struct packed {
        logic       inc;
        logic       dec;
        logic       load;
        logic [1:0] imm;
    } rfp_cmd_t;

    // debug bus, master side
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    // debug bus, slave side
    typedef struct packed {
        logic       pready;
        logic       pslverr;
        logic [7:0] prdata;
    } apb_rsp_t;

endpackage

// ==== rtl/rfp_ctrl.sv ====
`timescale 1ns/1ps
`include "regs_cfg.svh"

module rfp_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  regs_pkg::rfp_cmd_t  cmd,
    input  regs_pkg::reg_code_u src,
    input  regs_pkg::reg_code_u dst,
    input  regs_pkg::idx_cmd_t  idx,
    output logic [1:0]          rfp,
    output regs_pkg::reg_code_u src_abs,
    output regs_pkg::reg_code_u dst_abs
);

    regs_pkg::reg_code_u src_sel;

    // swap a relative bank nibble for the absolute one
    function automatic regs_pkg::reg_code_u resolve(
        input regs_pkg::reg_code_u code,
        input logic [1:0]          cur
    );
        regs_pkg::reg_code_u res;
        res = code;
        if (code.raw.bank_nib == `REG_CURBANK) begin
            res.raw.bank_nib = {2'b00, cur};
        end else if (code.raw.bank_nib == `REG_PREVBANK) begin
            res.raw.bank_nib = {2'b00, cur - 2'd1};
        end
        return res;
    endfunction

    // indexed addressing takes over the source port
    assign src_sel = idx.idx_en ? idx.idx_sel : src;

    assign src_abs = resolve(src_sel, rfp);
    assign dst_abs = resolve(dst, rfp);

    // load beats dec, dec beats inc
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (cen) begin
            if (cmd.load) begin
                rfp <= cmd.imm;
            end else if (cmd.dec) begin
                rfp <= rfp - 2'd1;
            end else if (cmd.inc) begin
                rfp <= rfp + 2'd1;
            end
        end
    end

    // decoder never asks for both directions at once
    rfp_no_inc_dec: assert property (
        @(posedge clk) disable iff (rst)
        cen |-> !(cmd.inc && cmd.dec)
    );

endmodule

// ==== rtl/reg_bank_file.sv ====
`timescale 1ns/1ps
`include "regs_cfg.svh"

module reg_bank_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [1:0]          rfp,
    input  regs_pkg::reg_code_u src_abs,
    input  regs_pkg::reg_code_u dst_abs,
    input  regs_pkg::idx_cmd_t  idx,
    input  regs_pkg::reg_wr_t   wr,
    input  logic [31:0]         alu_dout,
    input  logic [31:0]         ram_dout,
    input  logic [2:0]          dec_xsp,
    input  logic [7:0]          dmp_addr,
    output logic [31:0]         src_out,
    output logic [31:0]         dst_out,
    output logic [31:0]         xsp,
    output logic [7:0]          dmp_byte
);

    localparam int ACC_BYTES = `REG_BANKS * 16;
    localparam int PTR_BYTES = 16;

    logic [7:0] accs [ACC_BYTES];
    logic [7:0] ptrs [PTR_BYTES];

    logic [31:0]      step_val;
    logic [1:0]       ptr_grp;
    logic [31:0]      ptr_val;
    logic [31:0]      ptr_next;
    logic             step_en;
    logic [31:0]      xsp_next;
    logic [31:0]      wr_data;
    logic [2:0]       we;
    logic [3:0]       lane_we;
    logic [3:0][5:0]  lane_addr;
    logic [5:0]       dst_sel;

    // low byte sits at the select, upper bytes fill the aligned group
    function automatic logic [31:0] fetch(input regs_pkg::reg_code_u sel);
        logic [5:0]  a;
        logic [31:0] val;
        a = sel.resolved.acc_addr;
        if (sel.resolved.is_ptr) begin
            val = {ptrs[{a[3:2], 2'b11}], ptrs[{a[3:2], 2'b10}],
                   ptrs[{a[3:1], 1'b1}], ptrs[a[3:0]]};
        end else begin
            val = {accs[{a[5:2], 2'b11}], accs[{a[5:2], 2'b10}],
                   accs[{a[5:1], 1'b1}], accs[a]};
        end
        return val;
    endfunction

    always_comb begin
        case (idx.step)
            `STEP_1: step_val = 32'd1;
            `STEP_2: step_val = 32'd2;
            `STEP_4: step_val = 32'd4;
            default: step_val = 32'd1;
        endcase
    end

    // read ports
    always_comb begin
        if (src_abs.raw.bank_nib == `REG_ZERO_NIB) begin
            src_out = 32'd0;
        end else begin
            src_out = fetch(src_abs);
        end
    end

    // pre-decrement is visible on the same cycle
    always_comb begin
        dst_out = fetch(dst_abs);
        if (idx.dec) begin
            dst_out = dst_out - step_val;
        end
    end

    assign xsp = {ptrs[`XSP_BASE + 3], ptrs[`XSP_BASE + 2],
                  ptrs[`XSP_BASE + 1], ptrs[`XSP_BASE]};
    assign xsp_next = xsp - {29'd0, dec_xsp};

    // pointer named by the indexed select
    assign ptr_grp  = src_abs.resolved.acc_addr[3:2];
    assign ptr_val  = {ptrs[{ptr_grp, 2'd3}], ptrs[{ptr_grp, 2'd2}],
                       ptrs[{ptr_grp, 2'd1}], ptrs[{ptr_grp, 2'd0}]};
    assign ptr_next = idx.dec ? ptr_val - step_val : ptr_val + step_val;
    assign step_en  = idx.idx_en && (idx.inc || idx.dec);

    // write source and enables
    assign wr_data = wr.data_sel ? ram_dout : alu_dout;
    assign we      = wr.flag_only ? 3'b000 : (wr.data_sel ? wr.ram_we : wr.alu_we);
    assign dst_sel = dst_abs.resolved.acc_addr;

    // the widest enable covers the narrower ones
    always_comb begin
        lane_we = 4'b0000;
        for (int l = 0; l < 4; l++) begin
            lane_addr[l] = dst_sel;
        end
        if (we[2]) begin
            lane_we = 4'b1111;
            for (int l = 0; l < 4; l++) begin
                lane_addr[l] = {dst_sel[5:2], 2'(l)};
            end
        end else if (we[1]) begin
            lane_we = 4'b0011;
            for (int l = 0; l < 2; l++) begin
                lane_addr[l] = {dst_sel[5:1], 1'(l)};
            end
        end else if (we[0]) begin
            lane_we = 4'b0001;
        end
    end

    // step, then stack, then write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ACC_BYTES; i++) begin
                accs[i] <= 8'd0;
            end
            for (int i = 0; i < PTR_BYTES; i++) begin
                ptrs[i] <= 8'd0;
            end
        end else if (cen) begin
            if (step_en) begin
                for (int l = 0; l < 4; l++) begin
                    ptrs[{ptr_grp, 2'(l)}] <= ptr_next[8*l +: 8];
                end
            end
            if (dec_xsp != 3'd0) begin
                for (int l = 0; l < 4; l++) begin
                    ptrs[`XSP_BASE + l] <= xsp_next[8*l +: 8];
                end
            end
            for (int l = 0; l < 4; l++) begin
                if (lane_we[l]) begin
                    if (dst_abs.resolved.is_ptr) begin
                        ptrs[lane_addr[l][3:0]] <= wr_data[8*l +: 8];
                    end else begin
                        accs[lane_addr[l]] <= wr_data[8*l +: 8];
                    end
                end
            end
        end
    end

    // dump window: accumulators, then pointers, nothing above
    always_comb begin
        if (dmp_addr < `DMP_PTR_BASE) begin
            dmp_byte = accs[dmp_addr[5:0]];
        end else if (dmp_addr < `DMP_SR_HI) begin
            dmp_byte = ptrs[dmp_addr[3:0]];
        end else begin
            dmp_byte = 8'd0;
        end
    end

    // addresser issues one direction per step
    idx_no_inc_dec: assert property (
        @(posedge clk) disable iff (rst)
        cen |-> !(idx.inc && idx.dec)
    );

    // ALU result has a single width
    alu_we_onehot: assert property (
        @(posedge clk) disable iff (rst)
        cen |-> $onehot0(wr.alu_we)
    );

endmodule

// ==== rtl/reg_dump_apb.sv ====
`timescale 1ns/1ps
`include "regs_cfg.svh"

module reg_dump_apb (
    input  logic               clk,
    input  logic               rst,
    input  regs_pkg::apb_req_t req,
    input  logic [7:0]         dmp_byte,
    output logic [7:0]         dmp_addr,
    output regs_pkg::apb_rsp_t rsp
);

    logic [15:0] sr;
    logic        access;
    logic        is_sr_hi;
    logic        is_sr_lo;
    logic        bad_wr;
    logic        bad_rd;
    logic [7:0]  rd_mux;

    // register file decodes the address itself
    assign dmp_addr = req.paddr;

    assign access   = req.psel && req.penable;
    assign is_sr_hi = (req.paddr == `DMP_SR_HI);
    assign is_sr_lo = (req.paddr == `DMP_SR_LO);

    // only the status bytes are writable
    assign bad_wr = req.pwrite && !(is_sr_hi || is_sr_lo);
    assign bad_rd = !req.pwrite && (req.paddr > `DMP_SR_LO);

    always_comb begin
        if (is_sr_hi) begin
            rd_mux = sr[15:8];
        end else if (is_sr_lo) begin
            rd_mux = sr[7:0];
        end else begin
            rd_mux = dmp_byte;
        end
    end

    // zero wait states
    assign rsp.pready  = access;
    assign rsp.pslverr = access && (bad_wr || bad_rd);
    assign rsp.prdata  = (access && !req.pwrite) ? rd_mux : 8'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr <= 16'd0;
        end else if (access && req.pwrite) begin
            if (is_sr_hi) begin
                sr[15:8] <= req.pwdata;
            end
            if (is_sr_lo) begin
                sr[7:0] <= req.pwdata;
            end
        end
    end

    // access phase always follows a setup phase
    apb_setup_first: assert property (
        @(posedge clk) disable iff (rst)
        $rose(req.penable) |-> $past(req.psel)
    );

endmodule

// ==== rtl/reg_subsys_top.sv ====
`timescale 1ns/1ps

module reg_subsys_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  regs_pkg::rfp_cmd_t  rfp_cmd,
    input  regs_pkg::reg_code_u src,
    input  regs_pkg::reg_code_u dst,
    input  regs_pkg::idx_cmd_t  idx,
    input  regs_pkg::reg_wr_t   wr,
    input  logic [31:0]         alu_dout,
    input  logic [31:0]         ram_dout,
    input  logic [2:0]          dec_xsp,
    input  regs_pkg::apb_req_t  apb_req,
    output logic [31:0]         src_out,
    output logic [31:0]         dst_out,
    output logic [31:0]         xsp,
    output logic [1:0]          rfp,
    output regs_pkg::apb_rsp_t  apb_rsp
);

    regs_pkg::reg_code_u src_abs;
    regs_pkg::reg_code_u dst_abs;
    logic [7:0]          dmp_addr;
    logic [7:0]          dmp_byte;

    // bank pointer and code resolution
    rfp_ctrl u_rfp_ctrl (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .cmd     (rfp_cmd),
        .src     (src),
        .dst     (dst),
        .idx     (idx),
        .rfp     (rfp),
        .src_abs (src_abs),
        .dst_abs (dst_abs)
    );

    reg_bank_file u_reg_bank_file (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rfp      (rfp),
        .src_abs  (src_abs),
        .dst_abs  (dst_abs),
        .idx      (idx),
        .wr       (wr),
        .alu_dout (alu_dout),
        .ram_dout (ram_dout),
        .dec_xsp  (dec_xsp),
        .dmp_addr (dmp_addr),
        .src_out  (src_out),
        .dst_out  (dst_out),
        .xsp      (xsp),
        .dmp_byte (dmp_byte)
    );

    // debug access, runs without cen
    reg_dump_apb u_reg_dump_apb (
        .clk      (clk),
        .rst      (rst),
        .req      (apb_req),
        .dmp_byte (dmp_byte),
        .dmp_addr (dmp_addr),
        .rsp      (apb_rsp)
    );

endmodule

// ==== sim/reg_ref_model.svh ====
`ifndef REG_REF_MODEL_SVH
`define REG_REF_MODEL_SVH

// mirror of the register state
logic [7:0]  m_acc [64];
logic [7:0]  m_ptr [16];
logic [1:0]  m_rfp;
logic [15:0] m_sr;

function automatic void clear_model();
    foreach (m_acc[i]) m_acc[i] = 8'd0;
    foreach (m_ptr[i]) m_ptr[i] = 8'd0;
    m_rfp = 2'd0;
    m_sr = 16'd0;
endfunction

// current and previous bank codes follow rfp
function automatic logic [3:0] abs_nib(input logic [3:0] nib);
    if (nib == `REG_CURBANK) return {2'b00, m_rfp};
    if (nib == `REG_PREVBANK) return {2'b00, m_rfp - 2'd1};
    return nib;
endfunction

function automatic logic [31:0] ptr_word(input int g);
    return {m_ptr[4*g+3], m_ptr[4*g+2], m_ptr[4*g+1], m_ptr[4*g]};
endfunction

function automatic logic [31:0] step_size(input logic [1:0] step);
    return (step == `STEP_4) ? 32'd4 : ((step == `STEP_2) ? 32'd2 : 32'd1);
endfunction

// lane 0 is the named byte, upper lanes come from its aligned group
function automatic logic [31:0] read_code(input regs_pkg::reg_code_u code);
    logic [3:0]  nib;
    logic [5:0]  a;
    logic [5:0]  k;
    logic [31:0] v;
    nib = abs_nib(code.raw.bank_nib);
    a = {nib[1:0], code.raw.byte_idx};
    for (int l = 0; l < 4; l++) begin
        k = (l == 0) ? a : ((l == 1) ? (a | 6'd1) : ((a & 6'h3c) | 6'(l)));
        v[8*l +: 8] = nib[3] ? m_ptr[k[3:0]] : m_acc[k];
    end
    return v;
endfunction

function automatic logic [7:0] dump_byte(input logic [7:0] addr);
    if (addr < `DMP_PTR_BASE) return m_acc[addr[5:0]];
    if (addr < `DMP_SR_HI) return m_ptr[addr[3:0]];
    if (addr == `DMP_SR_HI) return m_sr[15:8];
    if (addr == `DMP_SR_LO) return m_sr[7:0];
    return 8'd0;
endfunction

// state after the coming edge, built from pre-edge values
function automatic void apply_edge();
    logic [7:0]  nacc [64];
    logic [7:0]  nptr [16];
    logic [3:0]  nib;
    logic [5:0]  a;
    logic [5:0]  k;
    logic [31:0] v;
    logic [2:0]  we;
    int          g;
    if (!cen) return;
    nacc = m_acc;
    nptr = m_ptr;
    g = int'(idx.idx_sel.raw.byte_idx[3:2]);
    if (idx.idx_en && (idx.inc || idx.dec)) begin
        v = idx.dec ? ptr_word(g) - step_size(idx.step) : ptr_word(g) + step_size(idx.step);
        for (int l = 0; l < 4; l++) nptr[4*g+l] = v[8*l +: 8];
    end
    if (dec_xsp != 3'd0) begin
        v = ptr_word(3) - {29'd0, dec_xsp};
        for (int l = 0; l < 4; l++) nptr[`XSP_BASE+l] = v[8*l +: 8];
    end
    // register write lands last
    we = wr.flag_only ? 3'b000 : (wr.data_sel ? wr.ram_we : wr.alu_we);
    v = wr.data_sel ? ram_dout : alu_dout;
    nib = abs_nib(dst.raw.bank_nib);
    a = {nib[1:0], dst.raw.byte_idx};
    for (int l = 0; l < 4; l++) begin
        if (we[2] || (we[1] && l < 2) || (we[0] && l == 0)) begin
            k = we[2] ? ((a & 6'h3c) | 6'(l)) : (we[1] ? ((a & 6'h3e) | 6'(l)) : a);
            if (nib[3]) nptr[k[3:0]] = v[8*l +: 8];
            else nacc[k] = v[8*l +: 8];
        end
    end
    if (rfp_cmd.load) m_rfp = rfp_cmd.imm;
    else if (rfp_cmd.dec) m_rfp = m_rfp - 2'd1;
    else if (rfp_cmd.inc) m_rfp = m_rfp + 2'd1;
    m_acc = nacc;
    m_ptr = nptr;
endfunction

`endif

// ==== sim/tb_reg_subsys.sv ====
`timescale 1ns/1ps
`include "regs_cfg.svh"

module tb_reg_subsys;

    localparam int PHASE = 320;
    localparam int APB_XFERS = 82 + 4 * 16 + 16;
    // reset, five core phases, two cycles per APB transfer, some slack
    localparam int PLAN_CYCLES = 16 + 5 * PHASE + 2 * APB_XFERS + 8;

    logic                clk = 1'b0;
    logic                rst;
    logic                cen;
    regs_pkg::rfp_cmd_t  rfp_cmd;
    regs_pkg::reg_code_u src;
    regs_pkg::reg_code_u dst;
    regs_pkg::idx_cmd_t  idx;
    regs_pkg::reg_wr_t   wr;
    logic [31:0]         alu_dout;
    logic [31:0]         ram_dout;
    logic [2:0]          dec_xsp;
    regs_pkg::apb_req_t  apb_req;
    logic [31:0]         src_out;
    logic [31:0]         dst_out;
    logic [31:0]         xsp;
    logic [1:0]          rfp;
    regs_pkg::apb_rsp_t  apb_rsp;
    int                  n_checks;
    int                  n_errors;

    `include "reg_ref_model.svh"

    reg_subsys_top dut (.*);

    always #2 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[ERROR] t=%0t %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // absolute banks, pointers, relative banks and the zero source
    function automatic regs_pkg::reg_code_u rand_code(input bit rel, input bit zero);
        regs_pkg::reg_code_u c;
        int r;
        r = $urandom_range(0, 9);
        c.raw.byte_idx = 4'($urandom);
        if (r < 4) c.raw.bank_nib = 4'(r);
        else if (r < 7) c.raw.bank_nib = !rel ? 4'(r - 4) :
                                         ((r == 6) ? `REG_PREVBANK : `REG_CURBANK);
        else if (r < 9) c.raw.bank_nib = 4'h8;
        else c.raw.bank_nib = zero ? `REG_ZERO_NIB : 4'h3;
        return c;
    endfunction

    task automatic drive_core(input bit use_rfp, input bit use_idx, input bit use_xsp);
        int r;
        cen = ($urandom_range(0, 3) != 0);
        src = rand_code(use_rfp, 1'b1);
        dst = rand_code(use_rfp, 1'b0);
        alu_dout = $urandom;
        ram_dout = $urandom;
        wr.data_sel = 1'($urandom);
        wr.alu_we = 3'(1 << $urandom_range(0, 3));
        wr.ram_we = 3'(1 << $urandom_range(0, 3));
        wr.flag_only = ($urandom_range(0, 7) == 0);
        r = use_rfp ? $urandom_range(0, 7) : 7;
        rfp_cmd.inc = (r == 0 || r == 3);
        rfp_cmd.dec = (r == 1);
        rfp_cmd.load = (r == 2 || r == 3);
        rfp_cmd.imm = 2'($urandom);
        idx = '0;
        if (use_idx && $urandom_range(0, 2) != 0) begin
            r = $urandom_range(0, 2);
            idx.idx_en = 1'b1;
            idx.idx_sel.raw.bank_nib = 4'h8;
            idx.idx_sel.raw.byte_idx = {2'($urandom), 2'b00};
            idx.step = 2'($urandom_range(0, 2));
            idx.inc = (r == 0);
            idx.dec = (r == 1);
            // dst then shows the whole pointer
            if ($urandom_range(0, 1) == 1) dst = idx.idx_sel;
        end
        dec_xsp = (use_xsp && $urandom_range(0, 1) == 1) ? 3'($urandom) : 3'd0;
    endtask

    task automatic run_core(input int cycles, input bit use_rfp, input bit use_idx,
                            input bit use_xsp);
        regs_pkg::reg_code_u s;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            drive_core(use_rfp, use_idx, use_xsp);
            // read ports settle well before the next edge
            #2;
            s = idx.idx_en ? idx.idx_sel : src;
            check_value("src_out", src_out,
                        (s.raw.bank_nib == `REG_ZERO_NIB) ? 32'd0 : read_code(s));
            check_value("dst_out", dst_out,
                        read_code(dst) - (idx.dec ? step_size(idx.step) : 32'd0));
            check_value("xsp", xsp, ptr_word(3));
            check_value("rfp", 32'(rfp), 32'(m_rfp));
            apply_edge();
        end
    endtask

    // setup cycle, then access cycle
    task automatic apb_check(input logic write, input logic [7:0] addr,
                             input logic [7:0] wdata, input logic exp_err);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        #2;
        check_value("pready in setup", 32'(apb_rsp.pready), 32'd0);
        check_value("pslverr in setup", 32'(apb_rsp.pslverr), 32'd0);
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #2;
        check_value("pready", 32'(apb_rsp.pready), 32'd1);
        check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
        if (!write) check_value("prdata", 32'(apb_rsp.prdata), 32'(dump_byte(addr)));
        else if (addr == `DMP_SR_HI) m_sr[15:8] = wdata;
        else if (addr == `DMP_SR_LO) m_sr[7:0] = wdata;
    endtask

    initial begin
        logic [7:0] addr;
        void'($urandom(32'h58334f2a));
        n_checks = 0;
        n_errors = 0;
        rst = 1'b1;
        cen = 1'b0;
        rfp_cmd = '0;
        src = '0;
        dst = '0;
        idx = '0;
        wr = '0;
        alu_dout = '0;
        ram_dout = '0;
        dec_xsp = '0;
        apb_req = '0;
        clear_model();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        #2;
        check_value("pready after reset", 32'(apb_rsp.pready), 32'd0);
        check_value("pslverr after reset", 32'(apb_rsp.pslverr), 32'd0);
        check_value("xsp after reset", xsp, 32'd0);
        run_core(PHASE, 1'b0, 1'b0, 1'b0);
        run_core(PHASE, 1'b1, 1'b0, 1'b0);
        run_core(PHASE, 1'b0, 1'b1, 1'b0);
        run_core(PHASE, 1'b0, 1'b0, 1'b1);
        run_core(PHASE, 1'b1, 1'b1, 1'b1);
        // core idle while the dump is read
        @(posedge clk);
        #1;
        cen = 1'b0;
        idx = '0;
        for (int a = 0; a <= `DMP_SR_LO; a++) apb_check(1'b0, 8'(a), 8'd0, 1'b0);
        repeat (16) begin
            addr = ($urandom_range(0, 1) == 1) ? `DMP_SR_HI : `DMP_SR_LO;
            apb_check(1'b1, addr, 8'($urandom), 1'b0);
            apb_check(1'b0, addr, 8'd0, 1'b0);
        end
        // register bytes are read only from the debug side
        repeat (16) begin
            addr = 8'($urandom_range(0, `DMP_SR_HI - 1));
            apb_check(1'b1, addr, 8'($urandom), 1'b1);
            apb_check(1'b0, addr, 8'd0, 1'b0);
        end
        repeat (16) apb_check(1'b0, 8'($urandom_range(`DMP_SR_LO + 1, 255)), 8'd0, 1'b1);
        @(posedge clk);
        #1;
        apb_req = '0;
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // twice the expected run length
    initial begin
        #(2 * PLAN_CYCLES * 4);
        $display("Timeout: the run did not finish within %0d ns", 2 * PLAN_CYCLES * 4);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
+incdir+sim
rtl/regs_pkg.sv
rtl/rfp_ctrl.sv
rtl/reg_bank_file.sv
rtl/reg_dump_apb.sv
rtl/reg_subsys_top.sv
sim/tb_reg_subsys.sv
